/* compile.f */
retire_pkg.sv
dispatch_ctrl.sv
exec_lane.sv
complete_arbiter.sv
rob.sv
retire_core.sv
tb_retire_core.sv

/* complete_arbiter.sv */
`timescale 1ns/1ps

module complete_arbiter (
	input  logic [retire_pkg::num_lanes-1:0] done,
	input  logic [retire_pkg::num_lanes*retire_pkg::rob_idx_w-1:0] lane_idx,
	input  logic [retire_pkg::num_lanes*retire_pkg::xlen-1:0] lane_result,
	input  logic [retire_pkg::num_lanes-1:0] lane_take_branch,

	output logic [retire_pkg::num_lanes-1:0] grant,
	output logic complete_en,
	output logic [retire_pkg::rob_idx_w-1:0] complete_idx,
	output logic [retire_pkg::xlen-1:0] result,
	output logic take_branch
);
	import retire_pkg::*;

	// Fixed priority, lane 0 first
	always_comb begin
		grant = '0;
		complete_en = 1'b0;
		complete_idx = '0;
		result = '0;
		take_branch = 1'b0;
		for (int i = num_lanes - 1; i >= 0; i--) begin
			if (done[i]) begin
				grant = '0;
				grant[i] = 1'b1;
				complete_en = 1'b1;
				complete_idx = lane_idx[i*rob_idx_w +: rob_idx_w];
				result = lane_result[i*xlen +: xlen];
				take_branch = lane_take_branch[i];
			end
		end
	end

endmodule

/* dispatch_ctrl.sv */
`timescale 1ns/1ps

module dispatch_ctrl (
	input  logic clock,
	input  logic rst,

	input  logic dispatch_en,
	input  logic [retire_pkg::op_w-1:0] op,
	input  logic [retire_pkg::xlen-1:0] src_a,
	input  logic [retire_pkg::xlen-1:0] src_b,
	input  logic [retire_pkg::reg_idx_w-1:0] dest_reg_idx,
	input  logic [retire_pkg::xlen-1:0] npc,
	input  logic [retire_pkg::tag_w-1:0] t_in,
	input  logic [retire_pkg::tag_w-1:0] t_old_in,

	input  logic free,
	input  logic [retire_pkg::rob_idx_w-1:0] free_idx,
	input  logic [retire_pkg::num_lanes-1:0] lane_idle,

	output logic dispatch_ready,
	output logic alloc_en,
	output logic [retire_pkg::tag_w-1:0] alloc_t,
	output logic [retire_pkg::tag_w-1:0] alloc_t_old,
	output logic [retire_pkg::reg_idx_w-1:0] alloc_dest_reg_idx,
	output logic [retire_pkg::xlen-1:0] alloc_npc,

	output logic [retire_pkg::num_lanes-1:0] start,
	output logic [retire_pkg::op_w-1:0] start_op,
	output logic [retire_pkg::xlen-1:0] start_a,
	output logic [retire_pkg::xlen-1:0] start_b,
	output logic [retire_pkg::rob_idx_w-1:0] start_rob_idx
);
	import retire_pkg::*;

	logic [num_lanes-1:0] lane_avail;
	logic [num_lanes-1:0] lane_sel;
	logic accept;

	// A lane with its start still in flight reports idle for one more cycle
	assign lane_avail = lane_idle & ~start;
	assign dispatch_ready = free && (|lane_avail);
	assign accept = dispatch_en && dispatch_ready;
	assign alloc_en = accept;

	// Entry fields for the rob, valid with alloc_en
	assign alloc_t = accept ? t_in : '0;
	assign alloc_t_old = accept ? t_old_in : '0;
	assign alloc_dest_reg_idx = accept ? dest_reg_idx : '0;
	assign alloc_npc = accept ? npc : '0;

	// Lowest available lane wins
	always_comb begin
		lane_sel = '0;
		for (int i = num_lanes - 1; i >= 0; i--) begin
			if (lane_avail[i]) begin
				lane_sel = '0;
				lane_sel[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			start <= '0;
		end else begin
			start <= accept ? lane_sel : '0;
		end
	end

	// Operands ride along with the strobe
	always_ff @(posedge clock) begin
		if (accept) begin
			start_op <= op;
			start_a <= src_a;
			start_b <= src_b;
			start_rob_idx <= free_idx;
		end
	end

endmodule

/* exec_lane.sv */
`timescale 1ns/1ps

module exec_lane (
	input  logic clock,
	input  logic rst,
	input  logic flush,

	input  logic start,
	input  logic [retire_pkg::op_w-1:0] op,
	input  logic [retire_pkg::xlen-1:0] a,
	input  logic [retire_pkg::xlen-1:0] b,
	input  logic [retire_pkg::rob_idx_w-1:0] rob_idx,
	input  logic grant,

	output logic idle,
	output logic done,
	output logic [retire_pkg::rob_idx_w-1:0] done_idx,
	output logic [retire_pkg::xlen-1:0] result,
	output logic take_branch
);
	import retire_pkg::*;

	logic busy;
	logic [$clog2(mul_cycles)-1:0] mul_cnt;
	logic [xlen-1:0] mcand;
	logic [xlen-1:0] mplier;
	logic [xlen-1:0] alu_out;

	assign idle = !busy && !done;

	// Single-cycle ops straight off the start operands
	always_comb begin
		case (op)
			op_add: alu_out = a + b;
			op_sub: alu_out = a - b;
			op_and: alu_out = a & b;
			op_xor: alu_out = a ^ b;
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			busy <= 1'b0;
			done <= 1'b0;
			mul_cnt <= '0;
		end else if (start) begin
			if (op == op_mul) begin
				busy <= 1'b1;
				mul_cnt <= ($bits(mul_cnt))'(mul_cycles - 2);
			end else begin
				done <= 1'b1;
			end
		end else if (busy) begin
			if (mul_cnt == 0) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				mul_cnt <= mul_cnt - 1'b1;
			end
		end else if (grant) begin
			done <= 1'b0;
		end
	end

	// Multiply takes one chunk of b per cycle, the first at the start edge
	always_ff @(posedge clock) begin
		if (start) begin
			done_idx <= rob_idx;
			take_branch <= (op == op_beq) && (a == b);
			if (op == op_mul) begin
				result <= a * b[mul_chunk_w-1:0];
				mcand <= a << mul_chunk_w;
				mplier <= b >> mul_chunk_w;
			end else begin
				result <= alu_out;
			end
		end else if (busy) begin
			result <= result + mcand * mplier[mul_chunk_w-1:0];
			mcand <= mcand << mul_chunk_w;
			mplier <= mplier >> mul_chunk_w;
		end
	end

endmodule

/* retire_core.sv */
`timescale 1ns/1ps

module retire_core (
	input  logic clock,
	input  logic rst,
	input  logic interrupt,
	input  logic ir_stall,

	input  logic dispatch_en,
	input  logic [retire_pkg::op_w-1:0] op,
	input  logic [retire_pkg::xlen-1:0] src_a,
	input  logic [retire_pkg::xlen-1:0] src_b,
	input  logic [retire_pkg::reg_idx_w-1:0] dest_reg_idx,
	input  logic [retire_pkg::xlen-1:0] npc,
	input  logic [retire_pkg::tag_w-1:0] t_in,
	input  logic [retire_pkg::tag_w-1:0] t_old_in,
	output logic dispatch_ready,

	output logic retire_en,
	output logic [retire_pkg::tag_w-1:0] retire_t,
	output logic [retire_pkg::tag_w-1:0] retire_t_old,
	output logic [retire_pkg::reg_idx_w-1:0] retire_dest_reg_idx,
	output logic [retire_pkg::xlen-1:0] retire_npc,
	output logic [retire_pkg::xlen-1:0] retire_result,
	output logic retire_take_branch
);
	import retire_pkg::*;

	logic free;
	logic [rob_idx_w-1:0] free_idx;
	logic alloc_en;
	logic [tag_w-1:0] alloc_t;
	logic [tag_w-1:0] alloc_t_old;
	logic [reg_idx_w-1:0] alloc_dest_reg_idx;
	logic [xlen-1:0] alloc_npc;

	logic [num_lanes-1:0] start;
	logic [op_w-1:0] start_op;
	logic [xlen-1:0] start_a;
	logic [xlen-1:0] start_b;
	logic [rob_idx_w-1:0] start_rob_idx;

	logic [num_lanes-1:0] lane_idle;
	logic [num_lanes-1:0] lane_done;
	logic [num_lanes-1:0] lane_grant;
	logic [num_lanes-1:0] lane_take_branch;
	logic [num_lanes*rob_idx_w-1:0] lane_idx;
	logic [num_lanes*xlen-1:0] lane_result;

	logic complete_en;
	logic [rob_idx_w-1:0] complete_idx;
	logic [xlen-1:0] complete_result;
	logic complete_take_branch;

	// Interrupt also drops a start strobe still on its way to a lane
	dispatch_ctrl dispatch_ctrl_i (
		.clock(clock),
		.rst(rst || interrupt),
		.dispatch_en(dispatch_en),
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.dest_reg_idx(dest_reg_idx),
		.npc(npc),
		.t_in(t_in),
		.t_old_in(t_old_in),
		.free(free),
		.free_idx(free_idx),
		.lane_idle(lane_idle),
		.dispatch_ready(dispatch_ready),
		.alloc_en(alloc_en),
		.alloc_t(alloc_t),
		.alloc_t_old(alloc_t_old),
		.alloc_dest_reg_idx(alloc_dest_reg_idx),
		.alloc_npc(alloc_npc),
		.start(start),
		.start_op(start_op),
		.start_a(start_a),
		.start_b(start_b),
		.start_rob_idx(start_rob_idx)
	);

	for (genvar g = 0; g < num_lanes; g++) begin : gen_lane
		exec_lane exec_lane_i (
			.clock(clock),
			.rst(rst),
			.flush(interrupt),
			.start(start[g]),
			.op(start_op),
			.a(start_a),
			.b(start_b),
			.rob_idx(start_rob_idx),
			.grant(lane_grant[g]),
			.idle(lane_idle[g]),
			.done(lane_done[g]),
			.done_idx(lane_idx[g*rob_idx_w +: rob_idx_w]),
			.result(lane_result[g*xlen +: xlen]),
			.take_branch(lane_take_branch[g])
		);
	end

	complete_arbiter complete_arbiter_i (
		.done(lane_done),
		.lane_idx(lane_idx),
		.lane_result(lane_result),
		.lane_take_branch(lane_take_branch),
		.grant(lane_grant),
		.complete_en(complete_en),
		.complete_idx(complete_idx),
		.result(complete_result),
		.take_branch(complete_take_branch)
	);

	rob rob_i (
		.clock(clock),
		.rst(rst),
		.interrupt(interrupt),
		.ir_stall(ir_stall),
		.alloc_en(alloc_en),
		.t_in(alloc_t),
		.t_old_in(alloc_t_old),
		.dest_reg_idx(alloc_dest_reg_idx),
		.npc(alloc_npc),
		.complete_en(complete_en),
		.complete_idx(complete_idx),
		.result(complete_result),
		.take_branch(complete_take_branch),
		.free(free),
		.free_idx(free_idx),
		.retire_en(retire_en),
		.retire_t(retire_t),
		.retire_t_old(retire_t_old),
		.retire_dest_reg_idx(retire_dest_reg_idx),
		.retire_npc(retire_npc),
		.retire_result(retire_result),
		.retire_take_branch(retire_take_branch)
	);

endmodule

/* retire_pkg.sv */
package retire_pkg;

	// Datapath and buffer sizing
	localparam int xlen = 32;
	localparam int rob_sz = 8;
	localparam int rob_idx_w = 3;
	localparam int rob_cnt_w = 4;
	localparam int tag_w = 6;
	localparam int reg_idx_w = 5;

	// Execution lanes
	localparam int num_lanes = 3;

	// Opcode encodings
	localparam int op_w = 3;
	localparam logic [op_w-1:0] op_add = 3'd0;
	localparam logic [op_w-1:0] op_sub = 3'd1;
	localparam logic [op_w-1:0] op_and = 3'd2;
	localparam logic [op_w-1:0] op_xor = 3'd3;
	localparam logic [op_w-1:0] op_beq = 3'd4;
	localparam logic [op_w-1:0] op_mul = 3'd5;

	// Multiply latency in a lane, counted from the start edge
	localparam int mul_cycles = 4;

	// Multiplier bits consumed per cycle
	localparam int mul_chunk_w = xlen / mul_cycles;

endpackage

/* rob.sv */
`timescale 1ns/1ps

module rob (
	input  logic clock,
	input  logic rst,
	input  logic interrupt,
	input  logic ir_stall,

	input  logic alloc_en,
	input  logic [retire_pkg::tag_w-1:0] t_in,
	input  logic [retire_pkg::tag_w-1:0] t_old_in,
	input  logic [retire_pkg::reg_idx_w-1:0] dest_reg_idx,
	input  logic [retire_pkg::xlen-1:0] npc,

	input  logic complete_en,
	input  logic [retire_pkg::rob_idx_w-1:0] complete_idx,
	input  logic [retire_pkg::xlen-1:0] result,
	input  logic take_branch,

	output logic free,
	output logic [retire_pkg::rob_idx_w-1:0] free_idx,

	output logic retire_en,
	output logic [retire_pkg::tag_w-1:0] retire_t,
	output logic [retire_pkg::tag_w-1:0] retire_t_old,
	output logic [retire_pkg::reg_idx_w-1:0] retire_dest_reg_idx,
	output logic [retire_pkg::xlen-1:0] retire_npc,
	output logic [retire_pkg::xlen-1:0] retire_result,
	output logic retire_take_branch
);
	import retire_pkg::*;

	logic [rob_sz-1:0] completed;
	logic [tag_w-1:0] ent_t [rob_sz];
	logic [tag_w-1:0] ent_t_old [rob_sz];
	logic [reg_idx_w-1:0] ent_dest [rob_sz];
	logic [xlen-1:0] ent_npc [rob_sz];
	logic [xlen-1:0] ent_result [rob_sz];
	logic ent_branch [rob_sz];

	logic [rob_idx_w-1:0] head;
	logic [rob_cnt_w-1:0] count;
	logic leave;

	assign free = count < rob_sz;
	assign retire_en = (count != 0) && completed[head];

	// Head only advances once the retire stage takes it
	assign leave = retire_en && !ir_stall;

	always_comb begin
		if (retire_en) begin
			retire_t = ent_t[head];
			retire_t_old = ent_t_old[head];
			retire_dest_reg_idx = ent_dest[head];
			retire_npc = ent_npc[head];
			retire_result = ent_result[head];
			retire_take_branch = ent_branch[head];
		end else begin
			retire_t = '0;
			retire_t_old = '0;
			retire_dest_reg_idx = '0;
			retire_npc = '0;
			retire_result = '0;
			retire_take_branch = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst || interrupt) begin
			head <= '0;
			free_idx <= '0;
			count <= '0;
			completed <= '0;
		end else begin
			if (alloc_en) begin
				completed[free_idx] <= 1'b0;
				free_idx <= free_idx + 1'b1;
			end
			if (complete_en) begin
				completed[complete_idx] <= 1'b1;
			end
			if (leave) begin
				completed[head] <= 1'b0;
				head <= head + 1'b1;
			end
			// Alloc and leave together keep the count
			case ({alloc_en, leave})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (alloc_en) begin
			ent_t[free_idx] <= t_in;
			ent_t_old[free_idx] <= t_old_in;
			ent_dest[free_idx] <= dest_reg_idx;
			ent_npc[free_idx] <= npc;
		end
		if (complete_en) begin
			ent_result[complete_idx] <= result;
			ent_branch[complete_idx] <= take_branch;
		end
	end

endmodule

/* tb_retire_core.sv */
`timescale 1ns/1ps

module tb_retire_core;
	import retire_pkg::*;

	typedef struct packed {
		logic [tag_w-1:0] t;
		logic [tag_w-1:0] t_old;
		logic [reg_idx_w-1:0] dest;
		logic [xlen-1:0] npc;
		logic [xlen-1:0] result;
		logic branch;
	} entry_t;

	localparam int wait_limit = 200;

	logic clock;
	logic rst;
	logic interrupt;
	logic ir_stall;
	logic dispatch_en;
	logic [op_w-1:0] op;
	logic [xlen-1:0] src_a;
	logic [xlen-1:0] src_b;
	logic [reg_idx_w-1:0] dest_reg_idx;
	logic [xlen-1:0] npc;
	logic [tag_w-1:0] t_in;
	logic [tag_w-1:0] t_old_in;
	logic dispatch_ready;
	logic retire_en;
	logic [tag_w-1:0] retire_t;
	logic [tag_w-1:0] retire_t_old;
	logic [reg_idx_w-1:0] retire_dest_reg_idx;
	logic [xlen-1:0] retire_npc;
	logic [xlen-1:0] retire_result;
	logic retire_take_branch;

	integer seed;
	int errors = 0;
	int timeouts = 0;
	int cycle = 0;
	entry_t exp_q[$];
	// Edge up to which each dispatched op surely still holds a lane
	int busy_q[$];
	entry_t held;
	bit hold_valid;
	bit stall_rand;
	bit saw_lanes_full;

	retire_core retire_core_i (
		.clock(clock),
		.rst(rst),
		.interrupt(interrupt),
		.ir_stall(ir_stall),
		.dispatch_en(dispatch_en),
		.op(op),
		.src_a(src_a),
		.src_b(src_b),
		.dest_reg_idx(dest_reg_idx),
		.npc(npc),
		.t_in(t_in),
		.t_old_in(t_old_in),
		.dispatch_ready(dispatch_ready),
		.retire_en(retire_en),
		.retire_t(retire_t),
		.retire_t_old(retire_t_old),
		.retire_dest_reg_idx(retire_dest_reg_idx),
		.retire_npc(retire_npc),
		.retire_result(retire_result),
		.retire_take_branch(retire_take_branch)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [xlen-1:0] expected_result(input logic [op_w-1:0] o,
			input logic [xlen-1:0] x, input logic [xlen-1:0] y);
		case (o)
			op_add: return x + y;
			op_sub: return x - y;
			op_and: return x & y;
			op_xor: return x ^ y;
			op_mul: return x * y;
			default: return '0;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [xlen-1:0] exp,
			input logic [xlen-1:0] act);
		assert (act === exp) else begin
			$display("Fail %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_entry(input entry_t e);
		compare_value("retire_t", e.t, retire_t);
		compare_value("retire_t_old", e.t_old, retire_t_old);
		compare_value("retire_dest_reg_idx", e.dest, retire_dest_reg_idx);
		compare_value("retire_npc", e.npc, retire_npc);
		compare_value("retire_result", e.result, retire_result);
		compare_value("retire_take_branch", e.branch, retire_take_branch);
	endtask

	// Reference model, sampled at the edge before the DUT updates
	always @(posedge clock) begin
		cycle++;
		if (rst || interrupt) begin
			exp_q.delete();
			busy_q.delete();
			hold_valid = 0;
		end else begin
			if (hold_valid) begin
				compare_value("retire_en", 1, retire_en);
				compare_entry(held);
			end
			hold_valid = retire_en && ir_stall;
			held = {retire_t, retire_t_old, retire_dest_reg_idx, retire_npc,
				retire_result, retire_take_branch};
			if (!retire_en) begin
				compare_entry('0);
			end else if (!ir_stall) begin
				assert (exp_q.size() > 0) else begin
					$display("Retirement seen with no operation outstanding");
					errors++;
				end
				if (exp_q.size() > 0)
					compare_entry(exp_q.pop_front());
			end
			for (int i = busy_q.size() - 1; i >= 0; i--) begin
				if (busy_q[i] < cycle)
					busy_q.delete(i);
			end
			if (busy_q.size() == num_lanes)
				saw_lanes_full = 1;
			if (dispatch_en && dispatch_ready) begin
				assert (busy_q.size() < num_lanes) else begin
					$display("Dispatch accepted while every lane still holds an operation");
					errors++;
				end
				exp_q.push_back(entry_t'({t_in, t_old_in, dest_reg_idx, npc,
					expected_result(op, src_a, src_b), op == op_beq && src_a == src_b}));
				busy_q.push_back(cycle + (op == op_mul ? mul_cycles : 1) + 1);
			end
		end
	end

	task automatic step();
		@(posedge clock);
		#1;
		if (stall_rand)
			ir_stall = (rand32() % 5) == 0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!dispatch_ready && n < wait_limit) begin
			step();
			n++;
		end
		assert (dispatch_ready) else begin
			$display("Timeout: dispatch_ready never rose");
			timeouts++;
		end
	endtask

	task automatic dispatch_one(input logic [op_w-1:0] o, input logic [xlen-1:0] x,
			input logic [xlen-1:0] y);
		logic [31:0] r;
		wait_ready();
		r = rand32();
		dispatch_en = 1;
		op = o;
		src_a = x;
		src_b = y;
		dest_reg_idx = r[reg_idx_w-1:0];
		t_in = r[8 +: tag_w];
		t_old_in = r[16 +: tag_w];
		npc = rand32();
		step();
		dispatch_en = 0;
	endtask

	task automatic random_dispatch();
		logic [31:0] r;
		logic [xlen-1:0] x;
		logic [xlen-1:0] y;
		r = rand32() % 6;
		x = rand32();
		y = rand32();
		// Equal operands now and then so beq gets taken
		if (rand32() % 4 == 0)
			y = x;
		dispatch_one(r[op_w-1:0], x, y);
	endtask

	task automatic drain();
		int n;
		stall_rand = 0;
		ir_stall = 0;
		n = 0;
		while (exp_q.size() > 0 && n < wait_limit) begin
			step();
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Timeout: %0d operations never retired", exp_q.size());
			timeouts++;
		end
	endtask

	initial begin
		int n;
		seed = 32'h61b9;
		clock = 0;
		rst = 1;
		interrupt = 0;
		ir_stall = 0;
		dispatch_en = 0;
		op = '0;
		src_a = '0;
		src_b = '0;
		dest_reg_idx = '0;
		npc = '0;
		t_in = '0;
		t_old_in = '0;
		stall_rand = 0;
		hold_valid = 0;
		saw_lanes_full = 0;
		repeat (5) @(posedge clock);
		#1;
		rst = 0;
		compare_value("retire_en", 0, retire_en);
		compare_entry('0);
		compare_value("dispatch_ready", 1, dispatch_ready);

		// Random mix with gaps and random retire stalls
		stall_rand = 1;
		repeat (120) begin
			while (rand32() % 3 == 0)
				step();
			random_dispatch();
		end
		drain();

		// Fill the rob behind a held stall
		ir_stall = 1;
		n = 0;
		while (exp_q.size() < rob_sz && n < wait_limit) begin
			random_dispatch();
			n++;
		end
		assert (exp_q.size() == rob_sz) else begin
			$display("Timeout: reorder buffer never filled under stall");
			timeouts++;
		end
		repeat (4) begin
			compare_value("dispatch_ready", 0, dispatch_ready);
			step();
		end
		ir_stall = 0;
		wait_ready();
		drain();

		// Interrupt with work in flight
		ir_stall = 1;
		repeat (5) random_dispatch();
		ir_stall = 0;
		interrupt = 1;
		step();
		interrupt = 0;
		repeat (4) begin
			compare_value("retire_en", 0, retire_en);
			compare_value("dispatch_ready", 1, dispatch_ready);
			step();
		end
		repeat (40) random_dispatch();
		drain();

		// Every lane busy with a multiply
		repeat (num_lanes) dispatch_one(op_mul, rand32(), rand32());
		compare_value("dispatch_ready", 0, dispatch_ready);
		// A younger add waits on the inputs until a lane frees up
		dispatch_en = 1;
		op = op_add;
		wait_ready();
		step();
		dispatch_en = 0;
		drain();

		assert (saw_lanes_full) else begin
			$display("All lanes were never seen busy at the same time");
			errors++;
		end
		$display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
